// File: Makefile
# Verilator flow for the settings_core control plane
VERILATOR ?= verilator
TOP       ?= settings_core_tb
FILELIST  ?= settings_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The log decides the result, so a missing pass line fails the target
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/settings_core_assert.sv
////////////////////////////////////////
// Bound into settings_wb_slave
// Ack is registered, so its request is checked one edge back
////////////////////////////////////////
`timescale 1ns/1ps

module settings_core_assert (
   input logic dsp_clk,
   input logic por_rst,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i,
   input logic push_i,
   input logic fifo_full_i
);

   int failures = 0;

   // Ack answers a request sampled on the previous edge
   ack_needs_request: assert property (@(posedge dsp_clk) disable iff (por_rst)
      ack_i |-> $past(cyc_i && stb_i))
      else begin
         failures++;
         $error("ack seen without cyc and stb on the previous edge");
      end

   ack_single_pulse: assert property (@(posedge dsp_clk) disable iff (por_rst)
      ack_i |=> !ack_i)
      else begin
         failures++;
         $error("ack held high for more than one cycle");
      end

   push_not_full: assert property (@(posedge dsp_clk) disable iff (por_rst)
      push_i |-> !fifo_full_i)
      else begin
         failures++;
         $error("settings FIFO pushed while full");
      end

endmodule

bind settings_wb_slave settings_core_assert u_assert (
   .dsp_clk(dsp_clk),
   .por_rst(por_rst),
   .cyc_i(wb_cyc_i),
   .stb_i(wb_stb_i),
   .ack_i(wb_ack_o),
   .push_i(push_o),
   .fifo_full_i(fifo_full_i)
);

// File: dv/settings_core_monitor.sv
////////////////////////////////////////
// Watches DUT outputs and compares them with expected values
// Output waits give up after OUT_TIMEOUT cycles
////////////////////////////////////////
`timescale 1ns/1ps

module settings_core_monitor (
   input logic                                   dsp_clk,
   input logic [settings_pkg::WB_DAT_W-1:0]      wb_dat_i,
   input logic [settings_pkg::CLOCK_CTRL_W-1:0]  clock_ctrl_i,
   input logic [settings_pkg::SERDES_CTRL_W-1:0] serdes_ctrl_i,
   input logic [settings_pkg::ADC_CTRL_W-1:0]    adc_ctrl_i,
   input logic                                   phy_reset_n_i,
   input logic [settings_pkg::LED_W-1:0]         leds_i
);
   import settings_pkg::*;

   localparam int OUT_TIMEOUT = 20;

   int error_count = 0;
   int check_count = 0;

   function automatic logic [31:0] output_value(input string port);
      if (port == "clock")       return 32'(clock_ctrl_i);
      else if (port == "serdes") return 32'(serdes_ctrl_i);
      else if (port == "adc")    return 32'(adc_ctrl_i);
      else if (port == "phy")    return 32'(phy_reset_n_i);
      else if (port == "leds")   return 32'(leds_i);
      else if (port == "rdata")  return wb_dat_i;   // Held until the next accept
      else                       return 'x;
   endfunction

   // Poll one output until it matches or the timeout runs out
   task automatic wait_output(input string port, input logic [31:0] exp, input string name);
      int cycles;
      cycles = 0;
      check_count++;
      while (output_value(port) !== exp && cycles < OUT_TIMEOUT) begin
         @(posedge dsp_clk);
         #1;
         cycles++;
      end
      if (output_value(port) !== exp) begin
         error_count++;
         $display("FAILED %s: expected %h, actual %h at %0t", name, exp,
                  output_value(port), $time);
      end
   endtask

   task automatic check_range(input string name, input logic [31:0] lo,
                              input logic [31:0] hi, input logic [31:0] act);
      check_count++;
      if (act < lo || act > hi) begin
         error_count++;
         $display("FAILED %s: expected %h to %h, actual %h", name, lo, hi, act);
      end
   endtask

   task automatic report_problem(input string msg);
      error_count++;
      $display("ERROR: %s at %0t", msg, $time);
   endtask

   task automatic final_report(input int assert_fails);
      $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
               check_count, error_count, assert_fails);
   endtask

endmodule

// File: dv/settings_core_tb.sv
////////////////////////////////////////
// Single Wishbone master driving settings_core from a step table
// Board status inputs stay constant for the whole run
////////////////////////////////////////
`timescale 1ns/1ps

module settings_core_tb;
   import settings_pkg::*;

   localparam int ACK_TIMEOUT = 20;

   logic                     dsp_clk;
   logic                     por_rst;
   logic                     wb_cyc;
   logic                     wb_stb;
   logic                     wb_we;
   logic [WB_ADR_W-1:0]      wb_adr;
   logic [WB_DAT_W-1:0]      wb_dat_w;
   logic [WB_DAT_W-1:0]      wb_dat_r;
   logic                     wb_ack;
   logic                     run_tx;
   logic                     run_rx;
   logic                     clk_status;
   logic                     link_up;
   logic                     button;
   logic [CLOCK_CTRL_W-1:0]  clock_ctrl;
   logic [SERDES_CTRL_W-1:0] serdes_ctrl;
   logic [ADC_CTRL_W-1:0]    adc_ctrl;
   logic                     phy_reset_n;
   logic [LED_W-1:0]         leds;

   ////////////////////////////////////////
   // Step table, one entry per index
   string               op_q[$];     // wr, rd or idle
   logic [WB_ADR_W-1:0] adr_q[$];
   logic [31:0]         dat_q[$];
   string               port_q[$];   // Output to check, or none
   logic [31:0]         exp_q[$];
   string               name_q[$];

   settings_core i_settings_core (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
      .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
      .run_tx_i(run_tx), .run_rx_i(run_rx), .clk_status_i(clk_status),
      .link_up_i(link_up), .button_i(button),
      .clock_ctrl_o(clock_ctrl), .serdes_ctrl_o(serdes_ctrl), .adc_ctrl_o(adc_ctrl),
      .phy_reset_n_o(phy_reset_n), .leds_o(leds)
   );

   settings_core_monitor i_monitor (
      .dsp_clk(dsp_clk), .wb_dat_i(wb_dat_r), .clock_ctrl_i(clock_ctrl),
      .serdes_ctrl_i(serdes_ctrl), .adc_ctrl_i(adc_ctrl),
      .phy_reset_n_i(phy_reset_n), .leds_i(leds)
   );

   always #5 dsp_clk = ~dsp_clk;

   function automatic logic [WB_ADR_W-1:0] set_byte_adr(input logic [SET_ADDR_W-1:0] a);
      return {a, 2'b00};
   endfunction

   function automatic logic [WB_ADR_W-1:0] rb_byte_adr(input logic [1:0] idx);
      logic [WB_ADR_W-1:0] a;
      a = '0;
      a[RB_WINDOW_BIT] = 1'b1;
      a[3:2] = idx;
      return a;
   endfunction

   // Hardware bit where the source bit is set, software bit elsewhere
   function automatic logic [31:0] led_expect(input logic [LED_W-1:0] src,
                                              input logic [LED_W-1:0] sw);
      logic [LED_W-1:0] leds_exp;
      logic             hw_bit;
      leds_exp = '0;
      for (int b = 0; b < LED_W; b++) begin
         case (b)
            1:       hw_bit = link_up;
            2:       hw_bit = clk_status;
            3:       hw_bit = run_rx;
            4:       hw_bit = run_tx;
            default: hw_bit = 1'b0;
         endcase
         leds_exp[b] = src[b] ? hw_bit : sw[b];
      end
      return 32'(leds_exp);
   endfunction

   task automatic add_step(input string op, input logic [WB_ADR_W-1:0] adr,
                           input logic [31:0] dat, input string port,
                           input logic [31:0] exp, input string name);
      op_q.push_back(op);
      adr_q.push_back(adr);
      dat_q.push_back(dat);
      port_q.push_back(port);
      exp_q.push_back(exp);
      name_q.push_back(name);
   endtask

   // Classic cycle; cyc and stb held until ack or timeout
   task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                             input logic [31:0] dat, output logic [31:0] rdata);
      int   cycles;
      logic acked;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dat;
      cycles   = 0;
      acked    = 1'b0;
      while (!acked && cycles < ACK_TIMEOUT) begin
         @(posedge dsp_clk);
         #1;
         acked = wb_ack;
         cycles++;
      end
      rdata  = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      if (!acked)
         i_monitor.report_problem($sformatf("no ack within %0d cycles, address %h",
                                            ACK_TIMEOUT, adr));
   endtask

   task automatic build_table();
      logic [31:0] d;
      logic [31:0] sw;
      logic [31:0] src;
      logic [31:0] status;
      add_step("idle", '0, '0, "leds", led_expect(LED_SRC_AT_RESET, 8'h00), "reset leds");
      add_step("idle", '0, '0, "clock", 32'h0, "reset clock");
      add_step("idle", '0, '0, "serdes", 32'h0, "reset serdes");
      add_step("idle", '0, '0, "adc", 32'h0, "reset adc");
      add_step("idle", '0, '0, "phy", 32'h1, "reset phy");
      // Misc registers, low bit forced so each output changes
      d = $urandom | 32'h1;
      add_step("wr", set_byte_adr(SR_MISC + MISC_CLOCK_OFS), d, "clock", d & 32'h1F, "clock");
      d = $urandom | 32'h1;
      add_step("wr", set_byte_adr(SR_MISC + MISC_SERDES_OFS), d, "serdes", d & 32'hF, "serdes");
      d = $urandom | 32'h1;
      add_step("wr", set_byte_adr(SR_MISC + MISC_ADC_OFS), d, "adc", d & 32'hF, "adc");
      add_step("wr", set_byte_adr(SR_MISC + MISC_PHY_OFS), 32'h1, "phy", 32'h0, "phy assert");
      add_step("wr", set_byte_adr(SR_MISC + MISC_PHY_OFS), 32'h0, "phy", 32'h1, "phy release");
      // LED bit 0 has no hardware source, forcing it makes each LED step visible
      sw  = ($urandom & 32'hFF) | 32'h1;
      src = ($urandom & 32'hFF) | 32'h1;
      add_step("wr", set_byte_adr(SR_MISC + MISC_LED_SW_OFS), sw, "leds",
               led_expect(LED_SRC_AT_RESET, sw[7:0]), "led software");
      add_step("wr", set_byte_adr(SR_MISC + MISC_LED_SRC_OFS), src, "leds",
               led_expect(src[7:0], sw[7:0]), "led mux");
      // Readback window
      status     = '0;
      status[13] = button;
      status[11] = clk_status;
      status[10] = link_up;
      add_step("rd", rb_byte_adr(RB_COMPAT), '0, "rdata", COMPAT_NUM, "compat word");
      add_step("rd", rb_byte_adr(RB_STATUS), '0, "rdata", status, "status word");
      add_step("rd", set_byte_adr(SR_MISC + MISC_ADC_OFS), '0, "rdata", 32'h0, "settings read");
      // Back-pressure burst with all LEDs on software
      add_step("wr", set_byte_adr(SR_MISC + MISC_LED_SRC_OFS), 32'h0, "leds",
               led_expect(8'h00, sw[7:0]), "led source cleared");
      for (int k = 0; k < 10; k++) begin
         d = $urandom & 32'hFF;
         add_step("wr", set_byte_adr(SR_MISC + MISC_LED_SW_OFS), d,
                  (k == 9) ? "leds" : "none", d, "led burst final");
      end
   endtask

   initial begin
      logic [31:0] rdata;
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] t1;
      logic [31:0] t2;
      int          tries;
      int          assert_fails;
      dsp_clk    = 1'b0;
      por_rst    = 1'b1;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      run_tx     = 1'b1;
      run_rx     = 1'b0;
      clk_status = 1'b1;
      link_up    = 1'b0;   // Differs from clk_status so swapped bits show
      button     = 1'b1;
      rdata      = $urandom(15625);   // Seeds the generator
      build_table();
      repeat (4) @(posedge dsp_clk);
      #1;
      por_rst = 1'b0;

      for (int i = 0; i < name_q.size(); i++) begin
         if (op_q[i] == "wr")
            bus_access(1'b1, adr_q[i], dat_q[i], rdata);
         else if (op_q[i] == "rd")
            bus_access(1'b0, adr_q[i], dat_q[i], rdata);
         if (port_q[i] != "none")
            i_monitor.wait_output(port_q[i], exp_q[i], name_q[i]);
      end

      ////////////////////////////////////////
      // Timer load, then poll time high until the load lands
      hi = $urandom | 32'h1;
      lo = $urandom & 32'h7FFF_FFFF;   // No carry within the check window
      bus_access(1'b1, set_byte_adr(SR_TIME64 + TIME_HI_OFS), hi, rdata);
      bus_access(1'b1, set_byte_adr(SR_TIME64 + TIME_LOAD_OFS), lo, rdata);
      tries = 0;
      rdata = '0;
      while (rdata != hi && tries < ACK_TIMEOUT) begin
         bus_access(1'b0, rb_byte_adr(RB_TIME_HI), '0, rdata);
         tries++;
      end
      i_monitor.wait_output("rdata", hi, "time high");
      bus_access(1'b0, rb_byte_adr(RB_TIME_LO), '0, t1);
      bus_access(1'b0, rb_byte_adr(RB_TIME_LO), '0, t2);
      i_monitor.check_range("time low first", lo, lo + 32'd100, t1);
      i_monitor.check_range("time low second", t1 + 32'd1, lo + 32'd100, t2);

      assert_fails = i_settings_core.u_wb_slave.u_assert.failures;
      i_monitor.final_report(assert_fails);
      if (i_monitor.error_count == 0 && assert_fails == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: settings_core.f
verilog/settings_pkg.sv
verilog/settings_fifo.sv
verilog/vita_timer.sv
verilog/misc_settings.sv
verilog/settings_wb_slave.sv
verilog/settings_core.sv
dv/settings_core_assert.sv
dv/settings_core_monitor.sv
dv/settings_core_tb.sv

// File: verilog/misc_settings.sv
////////////////////////////////////////
// Misc control registers at SR_MISC
// LED source bit 1 = hardware status, 0 = software value
////////////////////////////////////////
`timescale 1ns/1ps

module misc_settings (
   input  logic                                   dsp_clk,
   input  logic                                   por_rst,
   input  logic                                   set_stb_i,
   input  logic [settings_pkg::SET_ADDR_W-1:0]    set_addr_i,
   input  logic [settings_pkg::SET_DATA_W-1:0]    set_data_i,
   input  logic                                   run_tx_i,
   input  logic                                   run_rx_i,
   input  logic                                   clk_status_i,
   input  logic                                   link_up_i,
   output logic [settings_pkg::CLOCK_CTRL_W-1:0]  clock_ctrl_o,
   output logic [settings_pkg::SERDES_CTRL_W-1:0] serdes_ctrl_o,
   output logic [settings_pkg::ADC_CTRL_W-1:0]    adc_ctrl_o,
   output logic                                   phy_reset_n_o,
   output logic [settings_pkg::LED_W-1:0]         leds_o
);
   import settings_pkg::*;

   logic [LED_W-1:0] led_sw;
   logic [LED_W-1:0] led_src;
   logic [LED_W-1:0] led_hw;
   logic             phy_reset;   // Active high internally

   ////////////////////////////////////////
   // Register bank
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_ctrl_o  <= '0;
         serdes_ctrl_o <= '0;
         adc_ctrl_o    <= '0;
         led_sw        <= '0;
         phy_reset     <= 1'b0;
         led_src       <= LED_SRC_AT_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            SR_MISC + MISC_CLOCK_OFS:
               clock_ctrl_o <= set_data_i[CLOCK_CTRL_W-1:0];
            SR_MISC + MISC_SERDES_OFS:
               serdes_ctrl_o <= set_data_i[SERDES_CTRL_W-1:0];
            SR_MISC + MISC_ADC_OFS:
               adc_ctrl_o <= set_data_i[ADC_CTRL_W-1:0];
            SR_MISC + MISC_LED_SW_OFS:
               led_sw <= set_data_i[LED_W-1:0];
            SR_MISC + MISC_PHY_OFS:
               phy_reset <= set_data_i[0];
            SR_MISC + MISC_LED_SRC_OFS:
               led_src <= set_data_i[LED_W-1:0];
            default: ;                  // Not ours
         endcase
      end
   end

   assign phy_reset_n_o = ~phy_reset;

   ////////////////////////////////////////
   // LED mux
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, link_up_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: verilog/settings_core.sv
////////////////////////////////////////
// Settings control plane, all on dsp_clk
////////////////////////////////////////
`timescale 1ns/1ps

module settings_core (
   input  logic                                   dsp_clk,
   input  logic                                   por_rst,
   // Wishbone slave
   input  logic                                   wb_cyc_i,
   input  logic                                   wb_stb_i,
   input  logic                                   wb_we_i,
   input  logic [settings_pkg::WB_ADR_W-1:0]      wb_adr_i,
   input  logic [settings_pkg::WB_DAT_W-1:0]      wb_dat_i,
   output logic [settings_pkg::WB_DAT_W-1:0]      wb_dat_o,
   output logic                                   wb_ack_o,
   // Board status
   input  logic                                   run_tx_i,
   input  logic                                   run_rx_i,
   input  logic                                   clk_status_i,
   input  logic                                   link_up_i,
   input  logic                                   button_i,
   // Misc controls
   output logic [settings_pkg::CLOCK_CTRL_W-1:0]  clock_ctrl_o,
   output logic [settings_pkg::SERDES_CTRL_W-1:0] serdes_ctrl_o,
   output logic [settings_pkg::ADC_CTRL_W-1:0]    adc_ctrl_o,
   output logic                                   phy_reset_n_o,
   output logic [settings_pkg::LED_W-1:0]         leds_o
);
   import settings_pkg::*;

   logic                  push;
   logic [SET_ADDR_W-1:0] push_addr;
   logic [SET_DATA_W-1:0] push_data;
   logic                  fifo_full;
   logic                  set_stb;
   logic [SET_ADDR_W-1:0] set_addr;
   logic [SET_DATA_W-1:0] set_data;
   logic [TIME_W-1:0]     vita_time;

   ////////////////////////////////////////
   // Producer and buffer
   settings_wb_slave u_wb_slave (
      .dsp_clk, .por_rst,
      .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
      .push_o(push), .push_addr_o(push_addr), .push_data_o(push_data),
      .fifo_full_i(fifo_full), .vita_time_i(vita_time),
      .clk_status_i, .link_up_i, .button_i
   );

   settings_fifo #(.DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_settings_fifo (
      .dsp_clk, .por_rst,
      .push_i(push), .push_addr_i(push_addr), .push_data_i(push_data),
      .full_o(fifo_full),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data)
   );

   ////////////////////////////////////////
   // Consumers, each decodes its own addresses
   misc_settings u_misc_settings (
      .dsp_clk, .por_rst,
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .run_tx_i, .run_rx_i, .clk_status_i, .link_up_i,
      .clock_ctrl_o, .serdes_ctrl_o, .adc_ctrl_o, .phy_reset_n_o, .leds_o
   );

   vita_timer u_vita_timer (
      .dsp_clk, .por_rst,
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .vita_time_o(vita_time)
   );

endmodule

// File: verilog/settings_fifo.sv
////////////////////////////////////////
// Depth is 2**DEPTH_LOG2; pushes while full are dropped
////////////////////////////////////////
`timescale 1ns/1ps

module settings_fifo #(
   parameter int DEPTH_LOG2 = settings_pkg::FIFO_DEPTH_LOG2
) (
   input  logic                                dsp_clk,
   input  logic                                por_rst,
   input  logic                                push_i,
   input  logic [settings_pkg::SET_ADDR_W-1:0] push_addr_i,
   input  logic [settings_pkg::SET_DATA_W-1:0] push_data_i,
   output logic                                full_o,
   output logic                                set_stb_o,
   output logic [settings_pkg::SET_ADDR_W-1:0] set_addr_o,
   output logic [settings_pkg::SET_DATA_W-1:0] set_data_o
);
   import settings_pkg::*;

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   logic [SET_ADDR_W-1:0] addr_mem [DEPTH];
   logic [SET_DATA_W-1:0] data_mem [DEPTH];

   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  wr_en;
   logic                  rd_en;

   assign full_o = (count == (DEPTH_LOG2+1)'(DEPTH));
   assign wr_en  = push_i && !full_o;
   assign rd_en  = (count != '0);     // Drain as fast as possible

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         set_stb_o <= 1'b0;
      end else begin
         set_stb_o <= rd_en;
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (wr_en) begin
         addr_mem[wr_ptr] <= push_addr_i;
         data_mem[wr_ptr] <= push_data_i;
      end
      if (rd_en) begin
         set_addr_o <= addr_mem[rd_ptr];
         set_data_o <= data_mem[rd_ptr];
      end
   end

endmodule

// File: verilog/settings_pkg.sv
////////////////////////////////////////
// Settings addresses are word addresses (byte address / 4)
// Readback window selected by byte address bit 9
////////////////////////////////////////
package settings_pkg;

   // Bus widths
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;
   localparam int WB_ADR_W   = 10;
   localparam int WB_DAT_W   = 32;
   localparam int TIME_W     = 64;

   localparam int RB_WINDOW_BIT = 9;   // 0 = settings, 1 = readback

   ////////////////////////////////////////
   // Misc register block
   localparam logic [SET_ADDR_W-1:0] SR_MISC        = 8'd0;
   localparam logic [SET_ADDR_W-1:0] MISC_CLOCK_OFS = 8'd0;
   localparam logic [SET_ADDR_W-1:0] MISC_SERDES_OFS = 8'd1;
   localparam logic [SET_ADDR_W-1:0] MISC_ADC_OFS   = 8'd2;
   localparam logic [SET_ADDR_W-1:0] MISC_LED_SW_OFS = 8'd3;
   localparam logic [SET_ADDR_W-1:0] MISC_PHY_OFS   = 8'd4;
   localparam logic [SET_ADDR_W-1:0] MISC_LED_SRC_OFS = 8'd6;

   localparam int CLOCK_CTRL_W  = 5;
   localparam int SERDES_CTRL_W = 4;
   localparam int ADC_CTRL_W    = 4;
   localparam int LED_W         = 8;

   // 1 = hardware drives the LED, 0 = software value
   localparam logic [LED_W-1:0] LED_SRC_AT_RESET = 8'b0001_1110;

   ////////////////////////////////////////
   // VITA time
   localparam logic [SET_ADDR_W-1:0] SR_TIME64     = 8'd10;
   localparam logic [SET_ADDR_W-1:0] TIME_HI_OFS   = 8'd0;  // Pending high word
   localparam logic [SET_ADDR_W-1:0] TIME_LOAD_OFS = 8'd1;  // Low word, loads counter

   // Readback word indices
   localparam logic [1:0] RB_COMPAT  = 2'd0;
   localparam logic [1:0] RB_TIME_HI = 2'd1;
   localparam logic [1:0] RB_TIME_LO = 2'd2;
   localparam logic [1:0] RB_STATUS  = 2'd3;

   // Bump when the register map changes
   localparam logic [WB_DAT_W-1:0] COMPAT_NUM = {16'd8, 16'd2};  // Major, minor

   localparam int FIFO_DEPTH_LOG2 = 2;

   typedef enum logic [1:0] {IDLE, ACK, STALL} wb_state_t;

endpackage

// File: verilog/settings_wb_slave.sv
////////////////////////////////////////
// Single-master Wishbone classic slave
// Master must hold cyc/stb until ack; ack is one cycle wide
////////////////////////////////////////
`timescale 1ns/1ps

module settings_wb_slave (
   input  logic                              dsp_clk,
   input  logic                              por_rst,
   input  logic                              wb_cyc_i,
   input  logic                              wb_stb_i,
   input  logic                              wb_we_i,
   input  logic [settings_pkg::WB_ADR_W-1:0] wb_adr_i,
   input  logic [settings_pkg::WB_DAT_W-1:0] wb_dat_i,
   output logic [settings_pkg::WB_DAT_W-1:0] wb_dat_o,
   output logic                              wb_ack_o,
   output logic                              push_o,
   output logic [settings_pkg::SET_ADDR_W-1:0] push_addr_o,
   output logic [settings_pkg::SET_DATA_W-1:0] push_data_o,
   input  logic                              fifo_full_i,
   input  logic [settings_pkg::TIME_W-1:0]   vita_time_i,
   input  logic                              clk_status_i,
   input  logic                              link_up_i,
   input  logic                              button_i
);
   import settings_pkg::*;

   wb_state_t state;

   logic                bus_req;
   logic                set_write;   // Write into the settings window
   logic [1:0]          rb_idx;
   logic [WB_DAT_W-1:0] rb_word;
   logic [WB_DAT_W-1:0] status_word;

   assign bus_req   = wb_cyc_i && wb_stb_i;
   assign set_write = wb_we_i && !wb_adr_i[RB_WINDOW_BIT];
   assign rb_idx    = wb_adr_i[3:2];

   assign status_word = {18'b0, button_i, 1'b0, clk_status_i, link_up_i, 10'b0};

   ////////////////////////////////////////
   // Readback mux
   always_comb begin
      rb_word = '0;   // Settings window reads as zero
      if (wb_adr_i[RB_WINDOW_BIT]) begin
         case (rb_idx)
            RB_COMPAT:  rb_word = COMPAT_NUM;
            RB_TIME_HI: rb_word = vita_time_i[63:32];
            RB_TIME_LO: rb_word = vita_time_i[31:0];
            RB_STATUS:  rb_word = status_word;
            default:    rb_word = '0;
         endcase
      end
   end

   ////////////////////////////////////////
   // Handshake FSM
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state  <= IDLE;
         push_o <= 1'b0;
      end else begin
         push_o <= 1'b0;
         case (state)
            IDLE: begin
               if (bus_req) begin
                  if (set_write && fifo_full_i) begin
                     state <= STALL;            // Wait for FIFO space
                  end else begin
                     state  <= ACK;
                     push_o <= set_write;
                  end
               end
            end
            STALL: begin
               if (!bus_req) begin
                  state <= IDLE;                // Master gave up
               end else if (!fifo_full_i) begin
                  state  <= ACK;
                  push_o <= 1'b1;
               end
            end
            ACK:     state <= IDLE;             // Stb still high here, ignore it
            default: state <= IDLE;
         endcase
      end
   end

   // Captured on accept; held stable by the master while stalled
   always_ff @(posedge dsp_clk) begin
      if (state == IDLE && bus_req) begin
         push_addr_o <= wb_adr_i[WB_ADR_W-1:2];
         push_data_o <= wb_dat_i;
         wb_dat_o    <= rb_word;
      end
   end

   assign wb_ack_o = (state == ACK);

endmodule

// File: verilog/vita_timer.sv
////////////////////////////////////////
// Free-running 64-bit tick counter
// Write high word first, then low word to load
////////////////////////////////////////
`timescale 1ns/1ps

module vita_timer (
   input  logic                                dsp_clk,
   input  logic                                por_rst,
   input  logic                                set_stb_i,
   input  logic [settings_pkg::SET_ADDR_W-1:0] set_addr_i,
   input  logic [settings_pkg::SET_DATA_W-1:0] set_data_i,
   output logic [settings_pkg::TIME_W-1:0]     vita_time_o
);
   import settings_pkg::*;

   logic [SET_DATA_W-1:0] pending_hi;
   logic                  hi_write;
   logic                  load;

   assign hi_write = set_stb_i && (set_addr_i == SR_TIME64 + TIME_HI_OFS);
   assign load     = set_stb_i && (set_addr_i == SR_TIME64 + TIME_LOAD_OFS);

   // Held until the low word arrives
   always_ff @(posedge dsp_clk) begin
      if (hi_write) begin
         pending_hi <= set_data_i;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o <= '0;
      end else if (load) begin
         vita_time_o <= {pending_hi, set_data_i};
      end else begin
         vita_time_o <= vita_time_o + 1'b1;   // One tick per dsp_clk
      end
   end

endmodule
